//--- include/takum_defs.svh
`ifndef TAKUM_DEFS_SVH
`define TAKUM_DEFS_SVH

// Fixed takum16 words
`define TAKUM_NAR           16'h8000    // Not a real
`define TAKUM_ZERO          16'h0000

// Largest representable |l|, 254.9375 in Q8.16
`define TAKUM_BOUND_FIX     24'hFEF000

// Fraction bits of the fixed-point c + m
`define FRAC_BITS           16

// IEEE 754 single layout
`define FLOAT_EXP_BIAS      127
`define FLOAT_SIGN_BIT      31
`define FLOAT_EXP_MSB       30
`define FLOAT_EXP_LSB       23
`define FLOAT_MAN_MSB       22

// APB register map, byte offsets
`define REG_LOG             4'h0        // Write launches a conversion
`define REG_SIGN            4'h4
`define REG_RESULT          4'h8
`define REG_STATUS          4'hC

`endif

//--- rtl/takum_pkg.sv
`default_nettype none

package takum_pkg;

    // Encoded 16-bit takum
    typedef logic [15:0] takum16_t;

    // Direction bit plus 3-bit regime
    typedef logic [3:0] dr_t;

    // Mantissa bit count p, 4 to 11
    typedef logic [3:0] prec_t;

    typedef logic signed [8:0] char_t;  // Characteristic c, -255..254
    typedef logic [15:0] frac_t;        // Fraction m, unsigned Q0.16

    // Characteristic bias, -255..127
    typedef logic signed [9:0] bias_t;

    typedef logic [31:0] float32_t;     // IEEE 754 single

endpackage

`default_nettype wire

//--- rtl/apb_pkg.sv
`default_nettype none

package apb_pkg;

    // Byte address inside the register window
    typedef logic [3:0] paddr_t;

    // Read and write data word
    typedef logic [31:0] pdata_t;

endpackage

`default_nettype wire

//--- rtl/takum_log_decode.sv
`timescale 1ns/1ps
`default_nettype none
`include "takum_defs.svh"

module takum_log_decode (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire logic                launch,
    input  wire takum_pkg::float32_t log_value,
    input  wire logic                sign,
    output logic                     s1_valid,
    output logic                     s1_sign,
    output takum_pkg::char_t         s1_c,
    output takum_pkg::frac_t         s1_m,
    output logic                     s1_special,
    output takum_pkg::takum16_t      s1_special_word
);

    logic        sign_f;              // Sign of l
    logic [7:0]  exp_f;
    logic [22:0] man_f;
    logic [23:0] mant24;              // Mantissa with implicit one
    logic [7:0]  exp_shift;           // Right shift into Q8.16
    logic        overflow;            // |l| >= 256
    logic [23:0] mag_fix;             // Truncated |l| in Q8.16
    logic [23:0] mag_clamp;
    logic        negate;
    logic signed [24:0] cpm;          // c + m, signed Q9.16

    assign sign_f = log_value[`FLOAT_SIGN_BIT];
    assign exp_f  = log_value[`FLOAT_EXP_MSB:`FLOAT_EXP_LSB];
    assign man_f  = log_value[`FLOAT_MAN_MSB:0];
    assign mant24 = {1'b1, man_f};

    // Q1.23 mantissa times 2^(e-127) lands in Q8.16 after shifting by 134 - e
    assign exp_shift = 8'(`FLOAT_EXP_BIAS + 23 - `FRAC_BITS) - exp_f;

    always_comb begin
        mag_fix  = '0;
        overflow = 1'b0;
        if (exp_f >= 8'(`FLOAT_EXP_BIAS + 8)) begin
            overflow = 1'b1;          // Also covers inf and NaN
        end else if (exp_f != 8'd0) begin
            mag_fix = mant24 >> exp_shift; // Subnormals stay zero
        end
    end

    // Clamp on magnitude, then sign is applied
    assign mag_clamp = (overflow || (mag_fix > `TAKUM_BOUND_FIX)) ? `TAKUM_BOUND_FIX : mag_fix;

    assign negate = sign_f ^ sign;    // l sign combined with takum sign
    assign cpm    = negate ? -$signed({1'b0, mag_clamp}) : $signed({1'b0, mag_clamp});

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= launch;
        end
    end

    // Floor is the upper bits of two's complement fixed point
    always_ff @(posedge clk) begin
        s1_sign    <= sign;
        s1_c       <= cpm[`FRAC_BITS+8:`FRAC_BITS];
        s1_m       <= cpm[`FRAC_BITS-1:0];
        s1_special <= &exp_f;         // NaN or either infinity
        // Only -inf maps to zero
        s1_special_word <= (sign_f && (man_f == '0)) ? `TAKUM_ZERO : `TAKUM_NAR;
    end

endmodule

`default_nettype wire

//--- rtl/takum_regime_select.sv
`timescale 1ns/1ps
`default_nettype none

module takum_regime_select (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire logic                s1_valid,
    input  wire logic                s1_sign,
    input  wire takum_pkg::char_t    s1_c,
    input  wire takum_pkg::frac_t    s1_m,
    input  wire logic                s1_special,
    input  wire takum_pkg::takum16_t s1_special_word,
    output logic                     s2_valid,
    output logic                     s2_sign,
    output takum_pkg::char_t         s2_c,
    output takum_pkg::frac_t         s2_m,
    output logic                     s2_special,
    output takum_pkg::takum16_t      s2_special_word,
    output takum_pkg::dr_t           s2_dr,
    output takum_pkg::prec_t         s2_p,
    output takum_pkg::bias_t         s2_bias
);

    // Lower half 1 - 2^(r+1) with r = 7 - DR, upper half 2^r - 1 with r = DR - 8
    localparam takum_pkg::bias_t BIAS_LUT [16] = '{
        -10'sd255, -10'sd127, -10'sd63, -10'sd31, -10'sd15, -10'sd7, -10'sd3, -10'sd1,
        10'sd0, 10'sd1, 10'sd3, 10'sd7, 10'sd15, 10'sd31, 10'sd63, 10'sd127
    };

    // p = 11 - r
    localparam takum_pkg::prec_t PREC_LUT [16] = '{
        4'd4, 4'd5, 4'd6, 4'd7, 4'd8, 4'd9, 4'd10, 4'd11,
        4'd11, 4'd10, 4'd9, 4'd8, 4'd7, 4'd6, 4'd5, 4'd4
    };

    logic           half_up;          // c >= 0 selects DR 8..15
    takum_pkg::dr_t dr_sel;

    assign half_up = ~s1_c[8];

    // Highest DR in the half whose bias does not exceed c
    always_comb begin
        dr_sel = {half_up, 3'd0};
        for (int i = 1; i < 8; i++) begin
            if (takum_pkg::bias_t'(s1_c) >= BIAS_LUT[{half_up, 3'(i)}]) begin
                dr_sel = {half_up, 3'(i)};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            s2_valid <= 1'b0;
        end else begin
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        s2_sign         <= s1_sign;
        s2_c            <= s1_c;
        s2_m            <= s1_m;
        s2_special      <= s1_special;
        s2_special_word <= s1_special_word;
        s2_dr           <= dr_sel;
        s2_p            <= PREC_LUT[dr_sel];
        s2_bias         <= BIAS_LUT[dr_sel];
    end

endmodule

`default_nettype wire

//--- rtl/takum_assemble.sv
`timescale 1ns/1ps
`default_nettype none

module takum_assemble (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire logic                s2_valid,
    input  wire logic                s2_sign,
    input  wire takum_pkg::char_t    s2_c,
    input  wire takum_pkg::frac_t    s2_m,
    input  wire logic                s2_special,
    input  wire takum_pkg::takum16_t s2_special_word,
    input  wire takum_pkg::dr_t      s2_dr,
    input  wire takum_pkg::prec_t    s2_p,
    input  wire takum_pkg::bias_t    s2_bias,
    output logic                     result_valid,
    output takum_pkg::takum16_t      result,
    output logic                     result_special
);

    takum_pkg::bias_t    c_biased;    // c - bias, 0..127
    logic [4:0]          m_shift;
    takum_pkg::frac_t    m_bits;      // Top p bits of m, truncated
    takum_pkg::takum16_t word;

    assign c_biased = takum_pkg::bias_t'(s2_c) - s2_bias;
    assign m_shift  = 5'd16 - {1'b0, s2_p};
    assign m_bits   = s2_m >> m_shift;

    // S | DR | r characteristic bits | p mantissa bits
    assign word = {s2_sign, s2_dr, 11'd0} + (16'(c_biased[6:0]) << s2_p) + m_bits;

    always_ff @(posedge clk) begin
        if (reset) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= s2_valid;
        end
    end

    always_ff @(posedge clk) begin
        result         <= s2_special ? s2_special_word : word;
        result_special <= s2_special;
    end

endmodule

`default_nettype wire

//--- rtl/takum_apb_regs.sv
`timescale 1ns/1ps
`default_nettype none
`include "takum_defs.svh"

module takum_apb_regs (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire logic                psel,
    input  wire logic                penable,
    input  wire logic                pwrite,
    input  wire apb_pkg::paddr_t     paddr,
    input  wire apb_pkg::pdata_t     pwdata,
    output apb_pkg::pdata_t          prdata,
    output logic                     pready,
    output logic                     pslverr,
    output logic                     launch,
    output takum_pkg::float32_t      log_value,
    output logic                     sign,
    input  wire logic                busy,
    input  wire logic                result_valid,
    input  wire takum_pkg::takum16_t result,
    input  wire logic                result_special
);

    logic                setup;         // First APB cycle
    logic                access;        // Second APB cycle, transfer completes
    logic                addr_ok;
    logic                wr_en;
    logic                rd_result;     // RESULT read, clears done
    logic                done;
    takum_pkg::takum16_t result_q;
    logic                special_q;
    apb_pkg::pdata_t     rdata_mux;

    assign setup  = psel & ~penable;
    assign access = psel & penable;
    assign wr_en  = access & pwrite;
    assign rd_result = access & ~pwrite & (paddr == `REG_RESULT);

    assign addr_ok = (paddr == `REG_LOG) || (paddr == `REG_SIGN) ||
                     (paddr == `REG_RESULT) || (paddr == `REG_STATUS);

    assign pready  = 1'b1;              // Zero wait states
    assign pslverr = access & ~addr_ok;

    // Conversion starts straight from the bus
    assign launch    = wr_en & (paddr == `REG_LOG);
    assign log_value = pwdata;

    always_ff @(posedge clk) begin
        if (reset) begin
            sign      <= 1'b0;
            result_q  <= '0;
            special_q <= 1'b0;
            done      <= 1'b0;
        end else begin
            if (wr_en && (paddr == `REG_SIGN)) sign <= pwdata[0];
            if (result_valid) begin     // Newest result wins
                result_q  <= result;
                special_q <= result_special;
            end
            if (result_valid) done <= 1'b1;
            else if (rd_result) done <= 1'b0;
        end
    end

    always_comb begin
        case (paddr)
            `REG_SIGN:   rdata_mux = {31'd0, sign};
            `REG_RESULT: rdata_mux = {15'd0, special_q, result_q};
            `REG_STATUS: rdata_mux = {30'd0, busy, done};
            default:     rdata_mux = '0;  // LOG is write-only
        endcase
    end

    // Captured in setup so data is stable for the access cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            prdata <= '0;
        end else if (setup && !pwrite) begin
            prdata <= rdata_mux;
        end
    end

endmodule

`default_nettype wire

//--- rtl/takum16_encoder.sv
`timescale 1ns/1ps
`default_nettype none

module takum16_encoder (
    input  wire logic            clk,
    input  wire logic            reset,
    input  wire logic            psel,
    input  wire logic            penable,
    input  wire logic            pwrite,
    input  wire apb_pkg::paddr_t paddr,
    input  wire apb_pkg::pdata_t pwdata,
    output apb_pkg::pdata_t      prdata,
    output logic                 pready,
    output logic                 pslverr
);

    logic                launch;
    takum_pkg::float32_t log_value;
    logic                sign;
    logic                busy;

    // Stage 1 outputs
    logic                s1_valid;
    logic                s1_sign;
    takum_pkg::char_t    s1_c;
    takum_pkg::frac_t    s1_m;
    logic                s1_special;
    takum_pkg::takum16_t s1_special_word;

    // Stage 2 outputs
    logic                s2_valid;
    logic                s2_sign;
    takum_pkg::char_t    s2_c;
    takum_pkg::frac_t    s2_m;
    logic                s2_special;
    takum_pkg::takum16_t s2_special_word;
    takum_pkg::dr_t      s2_dr;
    takum_pkg::prec_t    s2_p;
    takum_pkg::bias_t    s2_bias;

    // Stage 3 outputs
    logic                result_valid;
    takum_pkg::takum16_t result;
    logic                result_special;

    assign busy = s1_valid | s2_valid | result_valid; // Any conversion in flight

    takum_apb_regs u_regs (
        .clk            (clk),
        .reset          (reset),
        .psel           (psel),
        .penable        (penable),
        .pwrite         (pwrite),
        .paddr          (paddr),
        .pwdata         (pwdata),
        .prdata         (prdata),
        .pready         (pready),
        .pslverr        (pslverr),
        .launch         (launch),
        .log_value      (log_value),
        .sign           (sign),
        .busy           (busy),
        .result_valid   (result_valid),
        .result         (result),
        .result_special (result_special)
    );

    takum_log_decode u_decode (
        .clk             (clk),
        .reset           (reset),
        .launch          (launch),
        .log_value       (log_value),
        .sign            (sign),
        .s1_valid        (s1_valid),
        .s1_sign         (s1_sign),
        .s1_c            (s1_c),
        .s1_m            (s1_m),
        .s1_special      (s1_special),
        .s1_special_word (s1_special_word)
    );

    takum_regime_select u_regime (
        .clk             (clk),
        .reset           (reset),
        .s1_valid        (s1_valid),
        .s1_sign         (s1_sign),
        .s1_c            (s1_c),
        .s1_m            (s1_m),
        .s1_special      (s1_special),
        .s1_special_word (s1_special_word),
        .s2_valid        (s2_valid),
        .s2_sign         (s2_sign),
        .s2_c            (s2_c),
        .s2_m            (s2_m),
        .s2_special      (s2_special),
        .s2_special_word (s2_special_word),
        .s2_dr           (s2_dr),
        .s2_p            (s2_p),
        .s2_bias         (s2_bias)
    );

    takum_assemble u_assemble (
        .clk             (clk),
        .reset           (reset),
        .s2_valid        (s2_valid),
        .s2_sign         (s2_sign),
        .s2_c            (s2_c),
        .s2_m            (s2_m),
        .s2_special      (s2_special),
        .s2_special_word (s2_special_word),
        .s2_dr           (s2_dr),
        .s2_p            (s2_p),
        .s2_bias         (s2_bias),
        .result_valid    (result_valid),
        .result          (result),
        .result_special  (result_special)
    );

endmodule

`default_nettype wire

//--- sim/takum16_encoder_properties.sv
`timescale 1ns/1ps
`default_nettype none
`include "takum_defs.svh"

module takum16_encoder_properties (
    input wire logic                clk,
    input wire logic                reset,
    input wire logic                psel,
    input wire logic                penable,
    input wire logic                pready,
    input wire logic                pslverr,
    input wire logic                result_valid,
    input wire logic                result_special,
    input wire takum_pkg::takum16_t result,
    input wire logic                done
);

    // Zero wait states
    a_pready_high: assert property (@(posedge clk) disable iff (reset) pready)
        else $error("pready low");

    // Error response only in the access phase
    a_pslverr_access: assert property (@(posedge clk) disable iff (reset)
        pslverr |-> (psel && penable))
        else $error("pslverr outside an access cycle");

    // Zero and NaR come only from specials since the clamp keeps c + m above -255
    a_special_word: assert property (@(posedge clk) disable iff (reset)
        result_valid |->
            (result_special == ((result == `TAKUM_ZERO) || (result == `TAKUM_NAR))))
        else $error("special flag and zero or NaR word disagree");

    a_done_follows: assert property (@(posedge clk) disable iff (reset)
        result_valid |=> done)
        else $error("done not set after result_valid");

endmodule

bind takum16_encoder takum16_encoder_properties u_props (
    .clk            (clk),
    .reset          (reset),
    .psel           (psel),
    .penable        (penable),
    .pready         (pready),
    .pslverr        (pslverr),
    .result_valid   (result_valid),
    .result_special (result_special),
    .result         (result),
    .done           (u_regs.done)
);

`default_nettype wire

//--- sim/tb_takum16_encoder.sv
`timescale 1ns/1ps
`default_nettype none
`include "takum_defs.svh"

module tb_takum16_encoder;

    localparam int HALF_PERIOD     = 50;
    localparam int CONVERSIONS     = 50;     // Upper estimate over all tests
    localparam int CYCLES_PER_CONV = 16;     // Sign write, LOG write, wait, polls, RESULT read
    // Twice the expected conversion time, plus reset and register accesses
    localparam int MAX_CYCLES      = 2 * CONVERSIONS * CYCLES_PER_CONV + 400;

    logic            clk = 1'b0;
    logic            reset;
    logic            psel;
    logic            penable;
    logic            pwrite;
    apb_pkg::paddr_t paddr;
    apb_pkg::pdata_t pwdata;
    apb_pkg::pdata_t prdata;
    logic            pready;
    logic            pslverr;

    int     checks = 0;
    int     errors = 0;
    int     cycles = 0;
    integer seed   = 32'hd5aa373f;
    logic   sign_reg = 1'b0;                 // Copy of the SIGN register for the model

    takum16_encoder u_dut (
        .clk     (clk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    always #HALF_PERIOD clk = ~clk;

    // Run limit
    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: simulation still running after %0d cycles", cycles);
            $display("TESTS FAILED");
            $finish;
        end
    end

    task automatic expect_equal(input string what, input apb_pkg::pdata_t got,
                                input apb_pkg::pdata_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0d ns: %s read 0x%08h, expected 0x%08h",
                     $time, what, got, exp);
        end
    endtask

    // Called at a falling edge, returns at a falling edge with the bus idle
    task automatic apb_write(input apb_pkg::paddr_t addr, input apb_pkg::pdata_t data);
        psel    = 1'b1;                      // Setup phase
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;                      // Access phase, completes on next rising edge
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_read(input apb_pkg::paddr_t addr, output apb_pkg::pdata_t data,
                            output logic err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge clk);
        penable = 1'b1;
        #1;                                  // Mid access phase, outputs settled
        data = prdata;
        err  = pslverr;
        expect_equal("pready in access phase", {31'd0, pready}, 32'd1);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic set_sign(input logic s);
        apb_write(`REG_SIGN, {31'd0, s});
        sign_reg = s;
    endtask

    // Bias of a DR code, lower half 1 - 2^(r+1), upper half 2^r - 1
    function automatic int dr_bias(input int d);
        int b;
        if (d < 8) b = 1 - (1 << (8 - d));   // r = 7 - d
        else b = (1 << (d - 8)) - 1;         // r = d - 8
        return b;
    endfunction

    function automatic takum_pkg::float32_t real_to_float(input real v);
        logic [63:0]         d;
        takum_pkg::float32_t f;
        d = $realtobits(v);
        if (v == 0.0) f = {d[63], 31'd0};
        else f = {d[63], 8'(int'(d[62:52]) - 896), d[51:29]}; // Rebias 1023 to 127
        return f;
    endfunction

    // Expected {special, takum} for a float input and a SIGN value
    task automatic run_model(input takum_pkg::float32_t f, input logic s,
                             output logic [16:0] expected);
        int          exp_f;
        int          mag;
        int          cm;
        int          c;
        int          m;
        int          dr;
        int          r;
        int          bias;
        int          p;
        int          word;
        int          bound;
        real         mag_real;
        logic [63:0] dbits;
        bound = int'(`TAKUM_BOUND_FIX);
        exp_f = int'(f[30:23]);
        if (exp_f == 255) begin
            // NaN or +inf is NaR, -inf is zero
            if (f[31] && (f[22:0] == '0)) expected = {1'b1, `TAKUM_ZERO};
            else expected = {1'b1, `TAKUM_NAR};
        end else begin
            if (exp_f == 0) begin
                mag = 0;                     // Subnormals count as zero
            end else begin
                dbits    = {1'b0, 11'(exp_f + 896), f[22:0], 29'd0};
                mag_real = $bitstoreal(dbits);
                if (mag_real >= 256.0) mag = bound;
                else mag = $rtoi(mag_real * 65536.0); // Truncating Q8.16
            end
            if (mag > bound) mag = bound;
            cm = (f[31] ^ s) ? -mag : mag;   // c + m in Q.16
            c  = cm >>> 16;                  // Floor
            m  = cm & 'hFFFF;
            dr = (c < 0) ? 0 : 8;
            for (int d = dr + 1; d < dr + 8; d++) begin
                if (dr_bias(d) <= c) dr = d;
            end
            r    = (dr < 8) ? 7 - dr : dr - 8;
            bias = dr_bias(dr);
            p    = 11 - r;
            word = (int'(s) << 15) | (dr << 11) | ((c - bias) << p) | (m >> (16 - p));
            expected = {1'b0, 16'(word)};
        end
    endtask

    task automatic wait_for_done();
        apb_pkg::pdata_t status;
        logic            err;
        int              polls;
        repeat (4) @(negedge clk);           // Pipeline latency
        polls  = 0;
        status = '0;
        while (!status[0] && polls < 20) begin
            apb_read(`REG_STATUS, status, err);
            polls++;
        end
        if (!status[0]) begin
            errors++;
            $display("STATUS done bit never came up after %0d polls at %0d ns", polls, $time);
        end
    endtask

    task automatic convert_and_check(input takum_pkg::float32_t f, output apb_pkg::pdata_t rdata);
        logic [16:0] expected;
        logic        err;
        run_model(f, sign_reg, expected);
        apb_write(`REG_LOG, f);
        wait_for_done();
        apb_read(`REG_RESULT, rdata, err);   // Also clears done
        expect_equal($sformatf("RESULT for 0x%08h sign %0b", f, sign_reg), rdata,
                     {15'd0, expected});
    endtask

    task automatic report_test(input string name, input int start_errors);
        if (errors == start_errors) $display("%-22s ok", name);
        else $display("%-22s failed with %0d errors", name, errors - start_errors);
    endtask

    task automatic reset_and_registers();
        int              start_errors;
        apb_pkg::pdata_t rdata;
        logic            err;
        start_errors = errors;
        expect_equal("prdata after reset", prdata, '0);
        expect_equal("pslverr after reset", {31'd0, pslverr}, '0);
        apb_read(`REG_STATUS, rdata, err);
        expect_equal("STATUS after reset", rdata, '0);
        apb_read(`REG_SIGN, rdata, err);
        expect_equal("SIGN after reset", rdata, '0);
        apb_read(`REG_RESULT, rdata, err);
        expect_equal("RESULT after reset", rdata, '0);
        expect_equal("pslverr on RESULT", {31'd0, err}, '0);
        apb_read(`REG_LOG, rdata, err);      // Write-only
        expect_equal("LOG read", rdata, '0);
        set_sign(1'b1);
        apb_read(`REG_SIGN, rdata, err);
        expect_equal("SIGN readback 1", rdata, 32'd1);
        set_sign(1'b0);
        apb_read(`REG_SIGN, rdata, err);
        expect_equal("SIGN readback 0", rdata, '0);
        apb_read(4'h2, rdata, err);
        expect_equal("pslverr at 0x2", {31'd0, err}, 32'd1);
        apb_read(4'hE, rdata, err);
        expect_equal("pslverr at 0xE", {31'd0, err}, 32'd1);
        report_test("reset_and_registers", start_errors);
    endtask

    task automatic special_inputs();
        int              start_errors;
        apb_pkg::pdata_t rdata;
        start_errors = errors;
        for (int s = 0; s < 2; s++) begin
            set_sign(1'(s));
            convert_and_check(32'h7FC00000, rdata);  // NaN
            convert_and_check(32'hFFC00001, rdata);  // Negative NaN
            convert_and_check(32'h7F800000, rdata);  // +inf
            convert_and_check(32'hFF800000, rdata);  // -inf
        end
        report_test("special_inputs", start_errors);
    endtask

    task automatic regime_sweep();
        int              start_errors;
        int              fix;
        real             value;
        real             values [11];
        apb_pkg::pdata_t rdata;
        start_errors = errors;
        values = '{0.0, 0.5, -0.5, -1.0, 1.0, 1.5, -3.25, 100.25, -100.0,
                   0.0009765625, -0.0009765625};
        set_sign(1'b0);
        for (int i = 0; i < 11; i++) begin
            convert_and_check(real_to_float(values[i]), rdata);
        end
        for (int i = 0; i < 20; i++) begin
            fix   = $random(seed) & 'hFFFFFF;       // Q8.16 magnitude
            value = real'(fix) / 65536.0;
            if ($random(seed) & 1) value = -value;
            set_sign(1'($random(seed)));
            convert_and_check(real_to_float(value), rdata);
        end
        report_test("regime_sweep", start_errors);
    endtask

    task automatic sign_inversion();
        int              start_errors;
        apb_pkg::pdata_t plus_word;
        apb_pkg::pdata_t minus_word;
        start_errors = errors;
        set_sign(1'b0);
        convert_and_check(real_to_float(1.5), plus_word);
        set_sign(1'b1);
        convert_and_check(real_to_float(1.5), minus_word);
        // Direction bit flips with SIGN, S bit follows SIGN
        expect_equal("direction with SIGN 0", {31'd0, plus_word[14]}, 32'd1);
        expect_equal("direction with SIGN 1", {31'd0, minus_word[14]}, '0);
        expect_equal("S bit with SIGN 1", {31'd0, minus_word[15]}, 32'd1);
        set_sign(1'b0);
        report_test("sign_inversion", start_errors);
    endtask

    task automatic clamp_bounds();
        int              start_errors;
        apb_pkg::pdata_t rdata;
        logic [16:0]     bound_word;
        start_errors = errors;
        set_sign(1'b0);
        convert_and_check(real_to_float(300.0), rdata);
        expect_equal("clamped +300", rdata, 32'h0000_7FFF);
        run_model(real_to_float(-254.9375), 1'b0, bound_word);
        convert_and_check(real_to_float(-300.0), rdata);
        expect_equal("clamped -300", rdata, {15'd0, bound_word});
        report_test("clamp_bounds", start_errors);
    endtask

    task automatic back_to_back_launch();
        int                  start_errors;
        apb_pkg::pdata_t     rdata;
        logic                err;
        logic [16:0]         expected;
        takum_pkg::float32_t third;
        start_errors = errors;
        set_sign(1'b0);
        third = real_to_float(42.125);
        run_model(third, 1'b0, expected);
        apb_write(`REG_LOG, real_to_float(2.5));
        apb_write(`REG_LOG, real_to_float(-7.75));
        apb_write(`REG_LOG, third);
        apb_read(`REG_STATUS, rdata, err);
        expect_equal("busy while in flight", {31'd0, rdata[1]}, 32'd1);
        wait_for_done();
        apb_read(`REG_RESULT, rdata, err);
        expect_equal("RESULT after third launch", rdata, {15'd0, expected});
        apb_read(`REG_STATUS, rdata, err);
        expect_equal("STATUS after RESULT read", rdata, '0);
        report_test("back_to_back_launch", start_errors);
    endtask

    initial begin
        reset   = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        repeat (8) @(negedge clk);           // Eight rising edges in reset
        reset = 1'b0;
        reset_and_registers();
        special_inputs();
        regime_sweep();
        sign_inversion();
        clamp_bounds();
        back_to_back_launch();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
+incdir+include
rtl/takum_pkg.sv
rtl/apb_pkg.sv
rtl/takum_log_decode.sv
rtl/takum_regime_select.sv
rtl/takum_assemble.sv
rtl/takum_apb_regs.sv
rtl/takum16_encoder.sv
sim/takum16_encoder_properties.sv
sim/tb_takum16_encoder.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_takum16_encoder
FILELIST  ?= all.f
OBJDIR    ?= obj_dir
PASS_MSG  := TESTS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
